// ==== rvCorePkg.sv ====
package rvCorePkg;

    // widths with a meaning of their own
    typedef logic [31:0] word_t;
    typedef logic [4:0]  regIdx_t;
    typedef logic [7:0]  imemAddr_t;
    typedef logic [7:0]  dmemAddr_t;
    typedef logic [2:0]  aluOp_t;

    // memory depths in words
    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;

    // alu operation codes
    localparam aluOp_t ALU_ADD   = 3'd0;
    localparam aluOp_t ALU_SUB   = 3'd1;
    localparam aluOp_t ALU_AND   = 3'd2;
    localparam aluOp_t ALU_OR    = 3'd3;
    localparam aluOp_t ALU_XOR   = 3'd4;
    localparam aluOp_t ALU_SLT   = 3'd5;
    // passes operand b through, used by lui
    localparam aluOp_t ALU_PASSB = 3'd6;

    // major opcodes, instr[6:0]
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // control bundle from the decoder
    typedef struct packed {
        regIdx_t rs1;
        regIdx_t rs2;
        regIdx_t rd;
        word_t   imm;
        aluOp_t  aluOp;
        logic    useImm;
        logic    regWrite;
        logic    memRead;
        logic    memWrite;
        logic    isBranch;
        logic    branchNe;
    } decodedInstr_t;

    // one retired instruction as seen in writeback
    typedef struct packed {
        word_t   pc;
        regIdx_t rd;
        word_t   wdata;
        logic    writes;
    } retireInfo_t;

    // one data memory write
    typedef struct packed {
        dmemAddr_t addr;
        word_t     data;
    } storeInfo_t;

endpackage

// ==== rvDecoder.sv ====
module rvDecoder (
    input  rvCorePkg::word_t         instr,
    output rvCorePkg::decodedInstr_t dec
);
    import rvCorePkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        // start from a no-op, fields always taken from fixed positions
        dec       = '0;
        dec.rs1   = instr[19:15];
        dec.rs2   = instr[24:20];
        dec.rd    = instr[11:7];
        dec.aluOp = ALU_ADD;
        case (opcode)
            OPC_OP: begin
                dec.regWrite = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: dec.aluOp = ALU_ADD;
                    {7'b0100000, 3'b000}: dec.aluOp = ALU_SUB;
                    {7'b0000000, 3'b111}: dec.aluOp = ALU_AND;
                    {7'b0000000, 3'b110}: dec.aluOp = ALU_OR;
                    {7'b0000000, 3'b100}: dec.aluOp = ALU_XOR;
                    {7'b0000000, 3'b010}: dec.aluOp = ALU_SLT;
                    // anything else stays a no-op
                    default: dec.regWrite = 1'b0;
                endcase
            end
            OPC_OPIMM: begin
                // only addi is supported
                dec.imm      = {{20{instr[31]}}, instr[31:20]};
                dec.useImm   = 1'b1;
                dec.regWrite = (funct3 == 3'b000);
            end
            OPC_LUI: begin
                dec.imm      = {instr[31:12], 12'b0};
                dec.useImm   = 1'b1;
                dec.aluOp    = ALU_PASSB;
                dec.regWrite = 1'b1;
            end
            OPC_LOAD: begin
                // lw only, address is rs1 + I imm
                dec.imm      = {{20{instr[31]}}, instr[31:20]};
                dec.useImm   = 1'b1;
                dec.regWrite = (funct3 == 3'b010);
                dec.memRead  = (funct3 == 3'b010);
            end
            OPC_STORE: begin
                // sw only, S imm splits across two fields
                dec.imm      = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                dec.useImm   = 1'b1;
                dec.memWrite = (funct3 == 3'b010);
            end
            OPC_BRANCH: begin
                // B imm, bit 0 always zero
                dec.imm      = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                instr[11:8], 1'b0};
                dec.isBranch = (funct3 == 3'b000) || (funct3 == 3'b001);
                dec.branchNe = (funct3 == 3'b001);
            end
            default: ;
        endcase
    end

endmodule

// ==== rvRegFile.sv ====
module rvRegFile (
    input  logic               CLK,
    input  logic               rst,
    input  rvCorePkg::regIdx_t rs1,
    input  rvCorePkg::regIdx_t rs2,
    output rvCorePkg::word_t   rdata1,
    output rvCorePkg::word_t   rdata2,
    input  logic               we,
    input  rvCorePkg::regIdx_t wa,
    input  rvCorePkg::word_t   wd
);
    import rvCorePkg::*;

    word_t regs [32];

    // async read, x0 reads zero since it is never written
    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

    always_ff @(posedge CLK) begin
        if (rst) begin
            // every entry clears, x0 included
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

endmodule

// ==== rvExecute.sv ====
module rvExecute (
    input  rvCorePkg::decodedInstr_t dec,
    input  rvCorePkg::word_t         pc,
    input  rvCorePkg::word_t         rdata1,
    input  rvCorePkg::word_t         rdata2,
    input  logic                     fwdValid,
    input  rvCorePkg::regIdx_t       fwdRd,
    input  rvCorePkg::word_t         fwdData,
    output rvCorePkg::word_t         aluResult,
    output rvCorePkg::word_t         storeData,
    output logic                     branchTaken,
    output rvCorePkg::word_t         branchTarget
);
    import rvCorePkg::*;

    word_t opA;
    word_t opB;
    word_t aluB;
    logic  fwdA;
    logic  fwdB;

    // writeback result wins over the regfile read, x0 never forwarded
    assign fwdA = fwdValid && (fwdRd != '0) && (fwdRd == dec.rs1);
    assign fwdB = fwdValid && (fwdRd != '0) && (fwdRd == dec.rs2);

    assign opA = fwdA ? fwdData : rdata1;
    assign opB = fwdB ? fwdData : rdata2;

    // second alu input
    assign aluB = dec.useImm ? dec.imm : opB;

    always_comb begin
        case (dec.aluOp)
            ALU_ADD:   aluResult = opA + aluB;
            ALU_SUB:   aluResult = opA - aluB;
            ALU_AND:   aluResult = opA & aluB;
            ALU_OR:    aluResult = opA | aluB;
            ALU_XOR:   aluResult = opA ^ aluB;
            ALU_SLT:   aluResult = {31'b0, $signed(opA) < $signed(aluB)};
            ALU_PASSB: aluResult = aluB;
            default:   aluResult = opA + aluB;
        endcase
    end

    // sw data is rs2 after forwarding
    assign storeData = opB;

    // beq / bne compare the forwarded operands directly
    assign branchTaken  = dec.isBranch && ((opA == opB) ^ dec.branchNe);
    assign branchTarget = pc + dec.imm;

endmodule

// ==== rvCore.sv ====
module rvCore (
    input  logic                   CLK,
    input  logic                   rst,
    output rvCorePkg::imemAddr_t   imemAddr,
    input  rvCorePkg::word_t       instr,
    output logic                   dmemRead,
    output logic                   dmemWrite,
    output rvCorePkg::dmemAddr_t   dmemAddr,
    output rvCorePkg::word_t       dmemWdata,
    input  rvCorePkg::word_t       rdata,
    output logic                   retireValid,
    output rvCorePkg::retireInfo_t retire
);
    import rvCorePkg::*;

    // fetch
    word_t pc;

    // execute stage, instr itself comes straight from the imem read register
    logic          exValid;
    word_t         exPc;
    decodedInstr_t dec;
    word_t         rdata1;
    word_t         rdata2;
    word_t         aluResult;
    word_t         storeData;
    logic          branchTaken;
    word_t         branchTarget;
    logic          takeBranch;
    storeInfo_t    exStore;

    // writeback stage
    logic    wbValid;
    word_t   wbPc;
    regIdx_t wbRd;
    logic    wbRegWrite;
    logic    wbMemRead;
    word_t   wbAluResult;
    word_t   wbData;
    logic    wbWrites;

    rvDecoder uDecoder (
        .instr (instr),
        .dec   (dec)
    );

    rvRegFile uRegFile (
        .CLK    (CLK),
        .rst    (rst),
        .rs1    (dec.rs1),
        .rs2    (dec.rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (wbValid && wbRegWrite),
        .wa     (wbRd),
        .wd     (wbData)
    );

    rvExecute uExecute (
        .dec          (dec),
        .pc           (exPc),
        .rdata1       (rdata1),
        .rdata2       (rdata2),
        .fwdValid     (wbValid && wbRegWrite),
        .fwdRd        (wbRd),
        .fwdData      (wbData),
        .aluResult    (aluResult),
        .storeData    (storeData),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget)
    );

    // word index of the fetch address
    assign imemAddr = pc[9:2];

    // squashed slots must not redirect or touch memory
    assign takeBranch = exValid && branchTaken;
    assign dmemRead   = exValid && dec.memRead;
    assign dmemWrite  = exValid && dec.memWrite;

    assign exStore   = '{addr: aluResult[9:2], data: storeData};
    assign dmemAddr  = exStore.addr;
    assign dmemWdata = exStore.data;

    // load data arrives from the dmem in this same cycle
    assign wbData   = wbMemRead ? rdata : wbAluResult;
    assign wbWrites = wbRegWrite && (wbRd != '0);

    assign retireValid  = wbValid;
    assign retire.pc    = wbPc;
    assign retire.rd    = wbRd;
    // wdata reported as zero when nothing is written
    assign retire.wdata = wbWrites ? wbData : '0;
    assign retire.writes = wbWrites;

    always_ff @(posedge CLK) begin
        if (rst) begin
            pc         <= '0;
            exValid    <= 1'b0;
            wbValid    <= 1'b0;
            wbRegWrite <= 1'b0;
            wbMemRead  <= 1'b0;
        end else begin
            wbValid    <= exValid;
            wbRegWrite <= exValid && dec.regWrite;
            wbMemRead  <= exValid && dec.memRead;
            if (takeBranch) begin
                // redirect, and kill the fall-through instr now in flight
                pc      <= branchTarget;
                exValid <= 1'b0;
            end else begin
                pc      <= pc + 32'd4;
                exValid <= 1'b1;
            end
        end
    end

    // payload follows the instruction through the stages
    always_ff @(posedge CLK) begin
        exPc        <= pc;
        wbPc        <= exPc;
        wbRd        <= dec.rd;
        wbAluResult <= aluResult;
    end

endmodule

// ==== rvImem.sv ====
module rvImem (
    input  logic                 CLK,
    input  rvCorePkg::imemAddr_t addr,
    output rvCorePkg::word_t     instr,
    input  logic                 progWe,
    input  rvCorePkg::imemAddr_t progAddr,
    input  rvCorePkg::word_t     progData
);
    import rvCorePkg::*;

    word_t mem [IMEM_WORDS];

    always_ff @(posedge CLK) begin
        // program load port, only driven while the core is in reset
        if (progWe) begin
            mem[progAddr] <= progData;
        end
        // registered read, doubles as the fetch/execute register
        instr <= mem[addr];
    end

endmodule

// ==== rvDmem.sv ====
module rvDmem (
    input  logic                 CLK,
    input  logic                 read,
    input  logic                 write,
    input  rvCorePkg::dmemAddr_t addr,
    input  rvCorePkg::word_t     wdata,
    output rvCorePkg::word_t     rdata
);
    import rvCorePkg::*;

    word_t      mem [DMEM_WORDS];
    storeInfo_t wrReq;

    assign wrReq = '{addr: addr, data: wdata};

    always_ff @(posedge CLK) begin
        if (write) begin
            mem[wrReq.addr] <= wrReq.data;
        end
        // read data is ready one cycle later, in writeback
        if (read) begin
            rdata <= mem[addr];
        end
    end

endmodule

// ==== rvSystem.sv ====
module rvSystem (
    input  logic                   CLK,
    input  logic                   rst,
    input  logic                   progWe,
    input  rvCorePkg::imemAddr_t   progAddr,
    input  rvCorePkg::word_t       progData,
    output logic                   retireValid,
    output rvCorePkg::retireInfo_t retire,
    output logic                   storeValid,
    output rvCorePkg::storeInfo_t  store
);
    import rvCorePkg::*;

    imemAddr_t imemAddr;
    word_t     instr;
    logic      dmemRead;
    logic      dmemWrite;
    dmemAddr_t dmemAddr;
    word_t     dmemWdata;
    word_t     dmemRdata;

    rvCore uCore (
        .CLK         (CLK),
        .rst         (rst),
        .imemAddr    (imemAddr),
        .instr       (instr),
        .dmemRead    (dmemRead),
        .dmemWrite   (dmemWrite),
        .dmemAddr    (dmemAddr),
        .dmemWdata   (dmemWdata),
        .rdata       (dmemRdata),
        .retireValid (retireValid),
        .retire      (retire)
    );

    rvImem uImem (
        .CLK      (CLK),
        .addr     (imemAddr),
        .instr    (instr),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData)
    );

    rvDmem uDmem (
        .CLK   (CLK),
        .read  (dmemRead),
        .write (dmemWrite),
        .addr  (dmemAddr),
        .wdata (dmemWdata),
        .rdata (dmemRdata)
    );

    // store pulse coincides with the memory write edge
    assign storeValid = dmemWrite;
    assign store      = '{addr: dmemAddr, data: dmemWdata};

endmodule

// ==== tbRvSystem.sv ====
module tbRvSystem;
    import rvCorePkg::*;

    localparam int CLK_PERIOD     = 20;
    localparam int RESET_CYCLES   = 3;
    localparam int PROG_LEN       = 120;
    // load cycles, reset tail, 4 cycles per instruction and some slack
    localparam int TIMEOUT_CYCLES = PROG_LEN + RESET_CYCLES + 4 * PROG_LEN + 50;

    // instruction kinds used by the generator and the model
    localparam int KIND_ADD  = 0;
    localparam int KIND_SUB  = 1;
    localparam int KIND_AND  = 2;
    localparam int KIND_OR   = 3;
    localparam int KIND_XOR  = 4;
    localparam int KIND_SLT  = 5;
    localparam int KIND_ADDI = 6;
    localparam int KIND_LUI  = 7;
    localparam int KIND_LW   = 8;
    localparam int KIND_SW   = 9;
    localparam int KIND_BEQ  = 10;
    localparam int KIND_BNE  = 11;

    logic        CLK;
    logic        rst;
    logic        progWe;
    imemAddr_t   progAddr;
    word_t       progData;
    logic        retireValid;
    retireInfo_t retire;
    logic        storeValid;
    storeInfo_t  store;

    // program as fields and as encoded words
    int      kindA [PROG_LEN];
    regIdx_t rdA   [PROG_LEN];
    regIdx_t rs1A  [PROG_LEN];
    regIdx_t rs2A  [PROG_LEN];
    word_t   immA  [PROG_LEN];
    word_t   progWords [PROG_LEN];

    retireInfo_t expRetires [$];
    storeInfo_t  expStores [$];
    logic [31:0] rngState;
    logic        haltSeen;

    rvSystem u_dut (
        .CLK         (CLK),
        .rst         (rst),
        .progWe      (progWe),
        .progAddr    (progAddr),
        .progData    (progData),
        .retireValid (retireValid),
        .retire      (retire),
        .storeValid  (storeValid),
        .store       (store)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // xorshift32
    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "run stopped");
    endtask

    // standard RV32I encodings
    function automatic word_t encodeInstr(input int kind, input regIdx_t rd,
                                          input regIdx_t rs1, input regIdx_t rs2,
                                          input word_t imm);
        word_t w;
        case (kind)
            KIND_ADD:  w = {7'b0000000, rs2, rs1, 3'b000, rd, OPC_OP};
            KIND_SUB:  w = {7'b0100000, rs2, rs1, 3'b000, rd, OPC_OP};
            KIND_AND:  w = {7'b0000000, rs2, rs1, 3'b111, rd, OPC_OP};
            KIND_OR:   w = {7'b0000000, rs2, rs1, 3'b110, rd, OPC_OP};
            KIND_XOR:  w = {7'b0000000, rs2, rs1, 3'b100, rd, OPC_OP};
            KIND_SLT:  w = {7'b0000000, rs2, rs1, 3'b010, rd, OPC_OP};
            KIND_ADDI: w = {imm[11:0], rs1, 3'b000, rd, OPC_OPIMM};
            KIND_LUI:  w = {imm[19:0], rd, OPC_LUI};
            KIND_LW:   w = {imm[11:0], rs1, 3'b010, rd, OPC_LOAD};
            KIND_SW:   w = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
            KIND_BEQ:  w = {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], OPC_BRANCH};
            KIND_BNE:  w = {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], OPC_BRANCH};
            default:   w = '0;
        endcase
        return w;
    endfunction

    task automatic buildProgram();
        logic [31:0] r;
        logic [31:0] r2;
        int          kind;
        int          k;
        regIdx_t     rd;
        regIdx_t     rs1;
        regIdx_t     rs2;
        regIdx_t     prevRd;
        word_t       imm;
        prevRd = '0;
        for (int i = 0; i < PROG_LEN - 1; i++) begin
            r  = nextRand();
            r2 = nextRand();
            rd = {2'b00, r[2:0]};
            // lean on the previous rd to exercise forwarding
            rs1 = r[9] ? prevRd : {2'b00, r[5:3]};
            rs2 = r[10] ? prevRd : {2'b00, r[8:6]};
            kind = int'(r2 % 32'd12);
            if (i < 8) begin
                // seed registers x1..x7
                kind = r2[0] ? KIND_LUI : KIND_ADDI;
                rd   = regIdx_t'((i % 7) + 1);
            end else if (i < 16) begin
                // write every data word once before any load or branch
                kind = KIND_SW;
                imm  = word_t'((i - 8) * 4);
            end
            if ((kind == KIND_BEQ || kind == KIND_BNE) && (i + 2 > PROG_LEN - 1)) begin
                kind = KIND_ADDI;
            end
            case (kind)
                KIND_ADDI: imm = {{20{r[22]}}, r[22:11]};
                KIND_LUI:  imm = {12'b0, r[31:12]};
                KIND_LW:   imm = {27'b0, r[13:11], 2'b00};
                KIND_SW: begin
                    if (i >= 16) begin
                        imm = {27'b0, r[13:11], 2'b00};
                    end
                end
                KIND_BEQ, KIND_BNE: begin
                    // forward only, 2 to 6 instructions, never past the halt
                    k = 2 + int'(r2[15:8] % 8'd5);
                    if (i + k > PROG_LEN - 1) begin
                        k = PROG_LEN - 1 - i;
                    end
                    imm = word_t'(k * 4);
                end
                default: imm = '0;
            endcase
            // memory ops use x0 as base
            if (kind == KIND_LW || kind == KIND_SW) begin
                rs1 = '0;
            end
            if (kind == KIND_SW || kind == KIND_BEQ || kind == KIND_BNE) begin
                rd = '0;
            end else begin
                prevRd = rd;
            end
            kindA[i] = kind;
            rdA[i]   = rd;
            rs1A[i]  = rs1;
            rs2A[i]  = rs2;
            immA[i]  = imm;
        end
        // halt, beq x0,x0,0
        kindA[PROG_LEN - 1] = KIND_BEQ;
        rdA[PROG_LEN - 1]   = '0;
        rs1A[PROG_LEN - 1]  = '0;
        rs2A[PROG_LEN - 1]  = '0;
        immA[PROG_LEN - 1]  = '0;
        for (int i = 0; i < PROG_LEN; i++) begin
            progWords[i] = encodeInstr(kindA[i], rdA[i], rs1A[i], rs2A[i], immA[i]);
        end
    endtask

    // ISA-level execution, fills the expected queues
    task automatic runModel();
        word_t       regs [32];
        word_t       dmemModel [DMEM_WORDS];
        word_t       a;
        word_t       b;
        word_t       res;
        logic        wr;
        logic        taken;
        int          idx;
        retireInfo_t ri;
        storeInfo_t  si;
        foreach (regs[j]) regs[j] = '0;
        foreach (dmemModel[j]) dmemModel[j] = '0;
        idx = 0;
        while (idx < PROG_LEN) begin
            a     = regs[rs1A[idx]];
            b     = regs[rs2A[idx]];
            wr    = 1'b1;
            taken = 1'b0;
            res   = '0;
            case (kindA[idx])
                KIND_ADD:  res = a + b;
                KIND_SUB:  res = a - b;
                KIND_AND:  res = a & b;
                KIND_OR:   res = a | b;
                KIND_XOR:  res = a ^ b;
                KIND_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                KIND_ADDI: res = a + immA[idx];
                KIND_LUI:  res = immA[idx] << 12;
                KIND_LW:   res = dmemModel[dmemAddr_t'((a + immA[idx]) >> 2)];
                KIND_SW: begin
                    wr      = 1'b0;
                    si.addr = dmemAddr_t'((a + immA[idx]) >> 2);
                    si.data = b;
                    dmemModel[si.addr] = b;
                    expStores.push_back(si);
                end
                KIND_BEQ: begin
                    wr    = 1'b0;
                    taken = (a == b);
                end
                default: begin
                    wr    = 1'b0;
                    taken = (a != b);
                end
            endcase
            ri.pc     = word_t'(idx) << 2;
            ri.rd     = rdA[idx];
            ri.writes = wr && (rdA[idx] != '0);
            ri.wdata  = ri.writes ? res : '0;
            expRetires.push_back(ri);
            if (ri.writes) begin
                regs[rdA[idx]] = res;
            end
            if (idx == PROG_LEN - 1) begin
                break;
            end
            idx = taken ? idx + int'(immA[idx] >> 2) : idx + 1;
        end
    endtask

    // the monitor stops at the halt, so the queue always holds the next entry
    task automatic checkRetire(input retireInfo_t got);
        retireInfo_t exp;
        exp = expRetires.pop_front();
        if (got.pc !== exp.pc) begin
            failRun($sformatf("mismatch at %0t: retire.pc got %h expected %h",
                              $time, got.pc, exp.pc));
        end else if (got.writes !== exp.writes) begin
            failRun($sformatf("mismatch at %0t: retire.writes got %b expected %b",
                              $time, got.writes, exp.writes));
        end else if (exp.writes && (got.rd !== exp.rd)) begin
            failRun($sformatf("mismatch at %0t: retire.rd got %0d expected %0d",
                              $time, got.rd, exp.rd));
        end else if (got.wdata !== exp.wdata) begin
            failRun($sformatf("mismatch at %0t: retire.wdata got %h expected %h",
                              $time, got.wdata, exp.wdata));
        end
    endtask

    task automatic checkStore(input storeInfo_t got);
        storeInfo_t exp;
        if (expStores.size() == 0) begin
            failRun("store pulse with no store left in the model");
        end else begin
            exp = expStores.pop_front();
            if (got.addr !== exp.addr) begin
                failRun($sformatf("mismatch at %0t: store.addr got %h expected %h",
                                  $time, got.addr, exp.addr));
            end else if (got.data !== exp.data) begin
                failRun($sformatf("mismatch at %0t: store.data got %h expected %h",
                                  $time, got.data, exp.data));
            end
        end
    endtask

    // sample away from the rising edge
    always @(negedge CLK) begin
        if (rst) begin
            if (retireValid === 1'b1 || storeValid === 1'b1) begin
                failRun("retire or store pulse while reset is asserted");
            end
        end else if (!haltSeen) begin
            if (storeValid) begin
                checkStore(store);
            end
            if (retireValid) begin
                checkRetire(retire);
                // last expected entry is the halt
                if (expRetires.size() == 0) begin
                    haltSeen = 1'b1;
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        failRun("timeout, the halt instruction never retired");
    end

    initial begin
        rst      = 1'b1;
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        haltSeen = 1'b0;
        rngState = 32'd61;
        buildProgram();
        runModel();
        // load through the prog port while the core is held in reset
        for (int i = 0; i < PROG_LEN; i++) begin
            @(posedge CLK);
            #2;
            progWe   = 1'b1;
            progAddr = imemAddr_t'(i);
            progData = progWords[i];
        end
        @(posedge CLK);
        #2;
        progWe = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #2;
        rst = 1'b0;
        wait (haltSeen);
        if (expStores.size() != 0) begin
            failRun("halt retired with stores still missing");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

// ==== rvSystem.f ====
rvCorePkg.sv
rvDecoder.sv
rvRegFile.sv
rvExecute.sv
rvCore.sv
rvImem.sv
rvDmem.sv
rvSystem.sv
tbRvSystem.sv

// ==== run.sh ====
#!/bin/sh
# build and run the rvSystem testbench with Verilator
set -e

verilator --binary --timing --top-module tbRvSystem -f rvSystem.f -Mdir obj_dir -o simRvSystem

# the pipe keeps the log even when the simulation stops on an error
./obj_dir/simRvSystem | tee sim.log

if grep -q "Result: PASSED" sim.log; then
    echo "simulation ok"
else
    echo "simulation reported a failure"
    exit 1
fi
